//--- Makefile
SRCS := $(shell grep -v '^+' link_emu_top.f)

.PHONY: run clean

run: obj_dir/Vlink_emu_tb
	@out="$$(./obj_dir/Vlink_emu_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

obj_dir/Vlink_emu_tb: link_emu_top.f $(SRCS)
	verilator --binary --timing --top-module link_emu_tb -f link_emu_top.f

clean:
	rm -rf obj_dir

//--- dv/link_emu_tb.sv
`default_nettype none

module link_emu_tb;

    localparam int MAX_TESTS  = 16;
    localparam int RAND_TICKS = 40;
    localparam int RAND_HALF  = 6;
    localparam int NT         = link_emu_pkg::NUM_TAPS;

    logic                                emu_clk;
    logic                                emu_rst;
    logic [link_emu_pkg::HALF_W-1:0]     half_period;
    logic [link_emu_pkg::PRBS_W-1:0]     prbs_eqn;
    logic [link_emu_pkg::CURSOR_W-1:0]   cursor_sel;
    logic [link_emu_pkg::TAP_W-1:0]      chan_wdata0;
    logic [link_emu_pkg::TAP_W-1:0]      chan_wdata1;
    logic [link_emu_pkg::TAP_ADDR_W-1:0] chan_waddr;
    logic                                chan_we;
    logic                                clk_tx_o;
    logic                                rx_bit_o;
    logic                                rx_vld_o;
    logic [link_emu_pkg::CNT_W-1:0]      bit_cnt_o;
    logic [link_emu_pkg::CNT_W-1:0]      err_cnt_o;

    // test table as read from the data file
    reg [8*32-1:0] t_name [MAX_TESTS];
    int            t_half [MAX_TESTS];
    logic [31:0]   t_eqn [MAX_TESTS];
    int            t_cursor [MAX_TESTS];
    int            t_tap [MAX_TESTS][NT];
    int            t_ticks [MAX_TESTS];
    int            t_flip [MAX_TESTS];
    int            t_exp [MAX_TESTS];
    int            num_tests;

    int   cur_taps [NT];
    int   mismatches;
    int   failed_tests;
    int   wd_cycles;
    logic wd_armed;
    int   seed;

    tb_clk_gen clk_gen_i (.clk_o(emu_clk));

    link_emu_top DUT (
        .emu_clk       (emu_clk),
        .emu_rst       (emu_rst),
        .half_period_i (half_period),
        .prbs_eqn_i    (prbs_eqn),
        .cursor_i      (cursor_sel),
        .chan_wdata0_i (chan_wdata0),
        .chan_wdata1_i (chan_wdata1),
        .chan_waddr_i  (chan_waddr),
        .chan_we_i     (chan_we),
        .clk_tx_o      (clk_tx_o),
        .rx_bit_o      (rx_bit_o),
        .rx_vld_o      (rx_vld_o),
        .bit_cnt_o     (bit_cnt_o),
        .err_cnt_o     (err_cnt_o)
    );

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic check_val(input string sig, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("ERROR t=%0t %s: got %0d, expected %0d", $time, sig, got, exp);
        end
    endtask

    // inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge emu_clk);
        #1;
    endtask

    task automatic drive_tap_pair(input int addr, input int d0, input int d1);
        logic [31:0] a;
        logic [31:0] w0;
        logic [31:0] w1;
        a = addr;
        w0 = d0;
        w1 = d1;
        chan_waddr  = a[link_emu_pkg::TAP_ADDR_W-1:0];
        chan_wdata0 = w0[link_emu_pkg::TAP_W-1:0];
        chan_wdata1 = w1[link_emu_pkg::TAP_W-1:0];
        chan_we     = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // one test with reset, tap load and a compare per tick
    //////////////////////////////////////////////////

    task automatic run_test(input reg [8*32-1:0] name, input int half, input logic [31:0] eqn,
                            input int cursor, input int ticks, input int flip,
                            input int exp_err);
        logic [31:0] cfg;
        logic [31:0] state;
        logic [NT-1:0] hist;
        logic tx_bit;
        logic slice;
        int sample;
        int errs;
        int n;
        int cyc;
        int last_cyc;
        int high_cnt;
        int start_mism;

        start_mism = mismatches;
        emu_rst = 1'b1;
        cfg = half;
        half_period = cfg[link_emu_pkg::HALF_W-1:0];
        prbs_eqn = eqn;
        cfg = cursor;
        cursor_sel = cfg[link_emu_pkg::CURSOR_W-1:0];
        chan_we = 1'b0;
        repeat (8) next_cycle();
        check_val("rx_vld_o in reset", 32'(rx_vld_o), 0);
        check_val("bit_cnt_o in reset", 32'(bit_cnt_o), 0);
        check_val("err_cnt_o in reset", 32'(err_cnt_o), 0);

        // taps land before the first tick
        emu_rst = 1'b0;
        for (int a = 0; a < NT / 2; a++) begin
            drive_tap_pair(a, cur_taps[2*a], cur_taps[2*a+1]);
            next_cycle();
        end
        chan_we = 1'b0;

        state = link_emu_pkg::PRBS_INIT;
        hist = '0;
        errs = 0;
        n = 0;
        cyc = 0;
        last_cyc = 0;
        high_cnt = 0;
        while (n < ticks) begin
            next_cycle();
            chan_we = 1'b0;
            cyc++;
            if (clk_tx_o) begin
                high_cnt++;
            end
            if (rx_vld_o) begin
                n++;
                // transmitted bit, channel sum and slice for this tick
                tx_bit = state[0];
                hist = {hist[NT-2:0], tx_bit};
                sample = 0;
                for (int k = 0; k < NT; k++) begin
                    if (hist[k]) begin
                        sample += cur_taps[k];
                    end else begin
                        sample -= cur_taps[k];
                    end
                end
                slice = (sample >= 0);
                if (slice != hist[cursor]) begin
                    errs++;
                end
                state = {state[link_emu_pkg::PRBS_W-2:0], ^(state & eqn)};

                check_val("rx_bit_o", 32'(rx_bit_o), 32'(slice));
                check_val("bit_cnt_o", 32'(bit_cnt_o), n);
                check_val("err_cnt_o", 32'(err_cnt_o), errs);
                if (n > 1) begin
                    check_val("rx_vld_o spacing", cyc - last_cyc, 2 * half);
                    check_val("clk_tx_o high cycles", high_cnt, half);
                end
                last_cyc = cyc;
                high_cnt = 0;
                if (n == flip) begin
                    // invert the main tap from the next tick on
                    cur_taps[0] = -cur_taps[0];
                    drive_tap_pair(0, cur_taps[0], cur_taps[1]);
                end
            end
        end

        check_val("bit_cnt_o at end", 32'(bit_cnt_o), ticks);
        if (exp_err >= 0) begin
            check_val("model errors vs file", errs, exp_err);
            check_val("err_cnt_o vs file", 32'(err_cnt_o), exp_err);
        end
        if (mismatches == start_mism) begin
            $display("test %0s: pass, %0d ticks, %0d bit errors", name, ticks, errs);
        end else begin
            failed_tests++;
            $display("test %0s: FAIL, %0d mismatches", name, mismatches - start_mism);
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        int fd;
        int rc;
        int half;
        int cursor;
        int ticks;
        int flip;
        int exp_err;
        int tp [NT];
        reg [8*256-1:0] line;
        reg [8*32-1:0] nm;
        logic [31:0] eqn;

        emu_rst = 1'b1;
        half_period = 8'd4;
        prbs_eqn = '0;
        cursor_sel = '0;
        chan_wdata0 = '0;
        chan_wdata1 = '0;
        chan_waddr = '0;
        chan_we = 1'b0;
        mismatches = 0;
        failed_tests = 0;
        num_tests = 0;
        wd_cycles = 0;
        wd_armed = 1'b0;
        seed = 32'h2bd9_931e;

        fd = $fopen("dv/link_emu_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/link_emu_tests.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                rc = $sscanf(line, "%s %d %h %d %d %d %d %d %d %d %d %d %d %d %d",
                             nm, half, eqn, cursor, tp[0], tp[1], tp[2], tp[3],
                             tp[4], tp[5], tp[6], tp[7], ticks, flip, exp_err);
                // comment and blank lines fill fewer fields
                if (rc == 15 && num_tests < MAX_TESTS) begin
                    t_name[num_tests] = nm;
                    t_half[num_tests] = half;
                    t_eqn[num_tests] = eqn;
                    t_cursor[num_tests] = cursor;
                    for (int k = 0; k < NT; k++) begin
                        t_tap[num_tests][k] = tp[k];
                    end
                    t_ticks[num_tests] = ticks;
                    t_flip[num_tests] = flip;
                    t_exp[num_tests] = exp_err;
                    num_tests++;
                end
            end
            $fclose(fd);
            if (num_tests == 0) begin
                $display("no test lines found in dv/link_emu_tests.txt");
            end
        end

        // run length bound from the tick counts and half periods
        wd_cycles = 500 + (RAND_TICKS + 2) * 2 * RAND_HALF;
        for (int i = 0; i < num_tests; i++) begin
            wd_cycles += (t_ticks[i] + 2) * 2 * t_half[i] + 20;
        end
        wd_armed = 1'b1;

        for (int i = 0; i < num_tests; i++) begin
            for (int k = 0; k < NT; k++) begin
                cur_taps[k] = t_tap[i][k];
            end
            if (t_half[i] < 4) begin
                $display("test %0s: half period %0d is too short to load the taps",
                         t_name[i], t_half[i]);
                failed_tests++;
            end else begin
                run_test(t_name[i], t_half[i], t_eqn[i], t_cursor[i], t_ticks[i], t_flip[i],
                         t_exp[i]);
            end
        end

        // random taps with errors predicted by the model
        for (int k = 0; k < NT; k++) begin
            cur_taps[k] = $random(seed) % 1500;
        end
        run_test("random_taps", RAND_HALF, 32'h0000_0110, 0, RAND_TICKS, 0, -1);

        $display("tests run %0d, failed %0d, mismatches %0d",
                 num_tests + 1, failed_tests, mismatches);
        if (num_tests > 0 && failed_tests == 0 && mismatches == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (wd_armed === 1'b1);
        repeat (wd_cycles) @(posedge emu_clk);
        $display("watchdog expired, run took longer than %0d clock cycles", wd_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/link_emu_tests.txt
# name  half  eqn(hex)  cursor  tap0 .. tap7 (signed decimal)  ticks  flip  exp_err
# flip: tick after which tap 0 is negated, 0 keeps the taps fixed
identity_h4       4  00000060  0  1000      0    0     0  0  0  0  0  40   0   0
identity_h7       7  00006000  0  2000      0    0     0  0  0  0  0  30   0   0
cursor3_aligned   6  00000060  3     0      0    0  1000  0  0  0  0  40   0   0
cursor3_offset    4  00000060  0     0      0    0  1000  0  0  0  0  20   0  12
heavy_isi         5  00000060  0  1000  -1500  200  -100  0  0  0  0  24   0  14
tap_flip          4  00000060  0  1000      0    0     0  0  0  0  0  30  10  20

//--- dv/tb_clk_gen.sv
`default_nettype none

// free-running emulation clock, period of 4
module tb_clk_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #2 clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

//--- link_emu_top.f
verilog/link_emu_pkg.sv
verilog/tap_wr_if.sv
verilog/osc_tick.sv
verilog/prbs_gen.sv
verilog/chan_fir.sv
verilog/rx_checker.sv
verilog/link_emu_top.sv
dv/tb_clk_gen.sv
dv/link_emu_tb.sv

//--- verilog/chan_fir.sv
`default_nettype none

module chan_fir (
    input  wire                                    emu_clk,
    input  wire                                    emu_rst,
    input  wire                                    tick_i,
    input  wire                                    bit_i,
    tap_wr_if.dst                                  tap_wr,
    output logic signed [link_emu_pkg::SAMPLE_W-1:0] sample_o,
    output logic                                   sample_vld_o
);

    logic signed [link_emu_pkg::TAP_W-1:0] taps [link_emu_pkg::NUM_TAPS];

    // older bits only, the current bit comes straight from bit_i
    logic [link_emu_pkg::NUM_TAPS-2:0]       hist;
    logic [link_emu_pkg::NUM_TAPS-1:0]       hist_next;
    logic signed [link_emu_pkg::SAMPLE_W-1:0] sum_next;
    logic [link_emu_pkg::TAP_IDX_W-1:0]      idx_even;
    logic [link_emu_pkg::TAP_IDX_W-1:0]      idx_odd;

    function automatic logic signed [link_emu_pkg::SAMPLE_W-1:0] ext_tap(
        input logic signed [link_emu_pkg::TAP_W-1:0] tap
    );
        localparam int PAD = link_emu_pkg::SAMPLE_W - link_emu_pkg::TAP_W;
        return {{PAD{tap[link_emu_pkg::TAP_W-1]}}, tap};
    endfunction

    //////////////////////////////////////////////////
    // tap table
    //////////////////////////////////////////////////

    assign idx_even = {tap_wr.waddr, 1'b0};
    assign idx_odd  = {tap_wr.waddr, 1'b1};

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            for (int k = 0; k < link_emu_pkg::NUM_TAPS; k++) begin
                taps[k] <= '0;
            end
        end else if (tap_wr.we) begin
            taps[idx_even] <= tap_wr.wdata0;
            taps[idx_odd]  <= tap_wr.wdata1;
        end
    end

    //////////////////////////////////////////////////
    // bit history and FIR sum
    //////////////////////////////////////////////////

    // history as it will look after this tick
    assign hist_next = {hist, bit_i};

    // each bit maps to +1 or -1 times its tap
    always_comb begin
        sum_next = '0;
        for (int k = 0; k < link_emu_pkg::NUM_TAPS; k++) begin
            if (hist_next[k]) begin
                sum_next = sum_next + ext_tap(taps[k]);
            end else begin
                sum_next = sum_next - ext_tap(taps[k]);
            end
        end
    end

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            hist         <= '0;
            sample_vld_o <= 1'b0;
        end else begin
            sample_vld_o <= tick_i;
            if (tick_i) begin
                hist <= hist_next[link_emu_pkg::NUM_TAPS-2:0];
            end
        end
    end

    // sample captured on each tick
    always_ff @(posedge emu_clk) begin
        if (tick_i) begin
            sample_o <= sum_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/link_emu_pkg.sv
`default_nettype none

package link_emu_pkg;

    //////////////////////////////////////////////////
    // channel taps and samples
    //////////////////////////////////////////////////

    // one signed tap, also the width of a tap write word
    localparam int TAP_W = 18;
    localparam int NUM_TAPS = 8;
    // one address selects a pair of taps
    localparam int TAP_ADDR_W = 2;
    // index into the full tap table
    localparam int TAP_IDX_W = TAP_ADDR_W + 1;
    // wide enough that eight full-scale taps cannot overflow
    localparam int SAMPLE_W = 22;

    //////////////////////////////////////////////////
    // transmit clock and PRBS
    //////////////////////////////////////////////////

    localparam int HALF_W = 8;
    localparam int PRBS_W = 32;
    localparam logic [PRBS_W-1:0] PRBS_INIT = 32'h0000_0001;

    //////////////////////////////////////////////////
    // receiver checker
    //////////////////////////////////////////////////

    localparam int CURSOR_W = 3;
    // reference history deep enough for any cursor value
    localparam int REF_DEPTH = 2 ** CURSOR_W;
    // bit and error counters, both saturating
    localparam int CNT_W = 16;

endpackage

`default_nettype wire

//--- verilog/link_emu_top.sv
`default_nettype none

module link_emu_top (
    input  wire                                 emu_clk,
    input  wire                                 emu_rst,
    input  wire [link_emu_pkg::HALF_W-1:0]      half_period_i,
    input  wire [link_emu_pkg::PRBS_W-1:0]      prbs_eqn_i,
    input  wire [link_emu_pkg::CURSOR_W-1:0]    cursor_i,
    input  wire [link_emu_pkg::TAP_W-1:0]       chan_wdata0_i,
    input  wire [link_emu_pkg::TAP_W-1:0]       chan_wdata1_i,
    input  wire [link_emu_pkg::TAP_ADDR_W-1:0]  chan_waddr_i,
    input  wire                                 chan_we_i,
    output logic                                clk_tx_o,
    output logic                                rx_bit_o,
    output logic                                rx_vld_o,
    output logic [link_emu_pkg::CNT_W-1:0]      bit_cnt_o,
    output logic [link_emu_pkg::CNT_W-1:0]      err_cnt_o
);

    logic                                      tick;
    logic                                      tx_bit;
    logic signed [link_emu_pkg::SAMPLE_W-1:0]  sample;
    logic                                      sample_vld;

    //////////////////////////////////////////////////
    // tap writes, driven from the top ports
    //////////////////////////////////////////////////

    tap_wr_if tap_wr ();

    assign tap_wr.wdata0 = chan_wdata0_i;
    assign tap_wr.wdata1 = chan_wdata1_i;
    assign tap_wr.waddr  = chan_waddr_i;
    assign tap_wr.we     = chan_we_i;

    //////////////////////////////////////////////////
    // transmit side
    //////////////////////////////////////////////////

    osc_tick osc_i (
        .emu_clk       (emu_clk),
        .emu_rst       (emu_rst),
        .half_period_i (half_period_i),
        .clk_val_o     (clk_tx_o),
        .tick_o        (tick)
    );

    prbs_gen prbs_i (
        .emu_clk (emu_clk),
        .emu_rst (emu_rst),
        .tick_i  (tick),
        .eqn_i   (prbs_eqn_i),
        .bit_o   (tx_bit)
    );

    //////////////////////////////////////////////////
    // channel and receiver
    //////////////////////////////////////////////////

    chan_fir chan_i (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .tick_i       (tick),
        .bit_i        (tx_bit),
        .tap_wr       (tap_wr.dst),
        .sample_o     (sample),
        .sample_vld_o (sample_vld)
    );

    rx_checker rx_i (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .tx_bit_i     (tx_bit),
        .tick_i       (tick),
        .sample_i     (sample),
        .sample_vld_i (sample_vld),
        .cursor_i     (cursor_i),
        .rx_bit_o     (rx_bit_o),
        .rx_vld_o     (rx_vld_o),
        .bit_cnt_o    (bit_cnt_o),
        .err_cnt_o    (err_cnt_o)
    );

endmodule

`default_nettype wire

//--- verilog/osc_tick.sv
`default_nettype none

module osc_tick (
    input  wire                              emu_clk,
    input  wire                              emu_rst,
    input  wire [link_emu_pkg::HALF_W-1:0]   half_period_i,
    output logic                             clk_val_o,
    output logic                             tick_o
);

    logic [link_emu_pkg::HALF_W-1:0] half_eff;
    logic [link_emu_pkg::HALF_W-1:0] cnt;
    logic                            expire;

    // zero half period behaves like one
    assign half_eff = (half_period_i == '0) ? link_emu_pkg::HALF_W'(1) : half_period_i;
    assign expire   = (cnt == '0);

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            cnt       <= half_eff - 1'b1;
            clk_val_o <= 1'b0;
            tick_o    <= 1'b0;
        end else begin
            tick_o <= 1'b0;
            if (expire) begin
                cnt       <= half_eff - 1'b1;
                clk_val_o <= ~clk_val_o;
                // strobe lines up with the low-to-high toggle
                tick_o    <= ~clk_val_o;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/prbs_gen.sv
`default_nettype none

module prbs_gen (
    input  wire                              emu_clk,
    input  wire                              emu_rst,
    input  wire                              tick_i,
    input  wire [link_emu_pkg::PRBS_W-1:0]   eqn_i,
    output logic                             bit_o
);

    logic [link_emu_pkg::PRBS_W-1:0] state;
    logic                            fb_bit;

    // feedback from every tap selected by the equation
    assign fb_bit = ^(state & eqn_i);

    //////////////////////////////////////////////////
    // fibonacci LFSR
    //////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            state <= link_emu_pkg::PRBS_INIT;
        end else if (tick_i) begin
            state <= {state[link_emu_pkg::PRBS_W-2:0], fb_bit};
        end
    end

    // newest bit sits at position 0, stable between ticks
    assign bit_o = state[0];

endmodule

`default_nettype wire

//--- verilog/rx_checker.sv
`default_nettype none

module rx_checker (
    input  wire                                      emu_clk,
    input  wire                                      emu_rst,
    input  wire                                      tx_bit_i,
    input  wire                                      tick_i,
    input  wire signed [link_emu_pkg::SAMPLE_W-1:0]  sample_i,
    input  wire                                      sample_vld_i,
    input  wire [link_emu_pkg::CURSOR_W-1:0]         cursor_i,
    output logic                                     rx_bit_o,
    output logic                                     rx_vld_o,
    output logic [link_emu_pkg::CNT_W-1:0]           bit_cnt_o,
    output logic [link_emu_pkg::CNT_W-1:0]           err_cnt_o
);

    logic [link_emu_pkg::REF_DEPTH-1:0] ref_hist;
    logic                               slice;
    logic                               mismatch;

    // non-negative samples decide 1
    assign slice    = ~sample_i[link_emu_pkg::SAMPLE_W-1];
    assign mismatch = slice ^ ref_hist[cursor_i];

    //////////////////////////////////////////////////
    // reference history
    //////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            ref_hist <= '0;
        end else if (tick_i) begin
            ref_hist <= {ref_hist[link_emu_pkg::REF_DEPTH-2:0], tx_bit_i};
        end
    end

    //////////////////////////////////////////////////
    // slicer output and counters
    //////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            rx_bit_o  <= 1'b0;
            rx_vld_o  <= 1'b0;
            bit_cnt_o <= '0;
            err_cnt_o <= '0;
        end else begin
            rx_vld_o <= sample_vld_i;
            if (sample_vld_i) begin
                rx_bit_o <= slice;
                // both counters hold at full scale
                if (bit_cnt_o != '1) begin
                    bit_cnt_o <= bit_cnt_o + 1'b1;
                end
                if (mismatch && (err_cnt_o != '1)) begin
                    err_cnt_o <= err_cnt_o + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/tap_wr_if.sv
`default_nettype none

// tap pair write port into the channel model
interface tap_wr_if;

    logic [link_emu_pkg::TAP_W-1:0]      wdata0;
    logic [link_emu_pkg::TAP_W-1:0]      wdata1;
    logic [link_emu_pkg::TAP_ADDR_W-1:0] waddr;
    logic                                we;

    modport src (output wdata0, output wdata1, output waddr, output we);

    modport dst (input wdata0, input wdata1, input waddr, input we);

endinterface

`default_nettype wire
